// ==== verilog.f ====
rtl/nfcPkg.sv
rtl/nandBusIf.sv
rtl/keyLock.sv
rtl/byteMover.sv
rtl/copySequencer.sv
rtl/nandFlashCopier.sv
testbench/tbClock.sv
testbench/nandFlashModel.sv
testbench/nandFlashCopierTb.sv

// ==== Makefile ====
TOP = nandFlashCopierTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns -j 0 --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== testbench/nandFlashCopierTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module nandFlashCopierTb;

    localparam int Rows        = 4;
    localparam int MaxDigits   = 16;
    localparam int DriveDelay  = 2;
    localparam int CopyTimeout = 1_000_000; // A full copy takes roughly 560k cycles
    localparam int IdleWindow  = 2000;
    localparam int PrintLimit  = 8;
    localparam logic [7:0] ReadCmd    = 8'h00;
    localparam logic [7:0] ProgramCmd = 8'h80;
    localparam logic [7:0] ConfirmCmd = 8'h10;

    logic       clk;
    logic       rst;
    logic [3:0] key;
    logic       done;
    logic       randomBusy;
    logic [7:0] ioInA;
    logic [7:0] ioOutA;
    logic [7:0] ioInB;
    logic [7:0] ioOutB;
    logic       cleA, aleA, renA, wenA, readingA, rbA;
    logic       cleB, aleB, renB, wenB, readingB, rbB;

    // Stimulus table, one entry per row
    string      rowName   [0:Rows-1];
    logic [3:0] rowDigits [0:Rows-1][0:MaxDigits-1];
    int         rowLength [0:Rows-1];
    bit         rowCopy   [0:Rows-1];
    bit         rowMark   [0:Rows-1];
    bit         rowRandom [0:Rows-1];

    int errors = 0;
    int rowErrors = 0;
    int failedRows = 0;

    tbClock u_clock (
        .clk (clk)
    );

    nandFlashCopier u_dut (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .done     (done),
        .ioInA    (ioInA),
        .ioOutA   (ioOutA),
        .cleA     (cleA),
        .aleA     (aleA),
        .renA     (renA),
        .wenA     (wenA),
        .readingA (readingA),
        .rbA      (rbA),
        .ioInB    (ioInB),
        .ioOutB   (ioOutB),
        .cleB     (cleB),
        .aleB     (aleB),
        .renB     (renB),
        .wenB     (wenB),
        .readingB (readingB),
        .rbB      (rbB)
    );

    nandFlashModel #(.Source(1'b1)) modelA (
        .clk        (clk),
        .rst        (rst),
        .randomBusy (randomBusy),
        .cle        (cleA),
        .ale        (aleA),
        .ren        (renA),
        .wen        (wenA),
        .din        (ioOutA),
        .dout       (ioInA),
        .rb         (rbA)
    );

    nandFlashModel modelB (
        .clk        (clk),
        .rst        (rst),
        .randomBusy (randomBusy),
        .cle        (cleB),
        .ale        (aleB),
        .ren        (renB),
        .wen        (wenB),
        .din        (ioOutB),
        .dout       (ioInB),
        .rb         (rbB)
    );

    function automatic logic [7:0] sourceByte(input int p, input int i);
        return 8'(p * 7 + i);
    endfunction

    // Address cycles: column 0, column 0, page low, page high bit, idle
    function automatic logic [8:0] addressEntry(input int p, input int k);
        case (k)
            2:       return {1'b0, 8'(p)};
            3:       return {8'h00, 1'(p >> 8)};
            default: return 9'h000;
        endcase
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic reportMismatch(input string name, input int got, input int want);
        errors++;
        rowErrors++;
        if (rowErrors <= PrintLimit) begin
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic reportProblem(input string text);
        errors++;
        rowErrors++;
        $display("%s", text);
    endtask

    task automatic buildTable();
        for (int k = 0; k < 8; k++) begin
            rowDigits[0][k]     = nfcPkg::UnlockKey[k];
            rowDigits[1][k]     = nfcPkg::UnlockKey[k];
            rowDigits[2][k]     = nfcPkg::UnlockKey[k];
            rowDigits[2][k + 8] = nfcPkg::UnlockKey[k];
            rowDigits[3][k]     = nfcPkg::UnlockKey[k];
        end
        rowDigits[1][2] = ~nfcPkg::UnlockKey[2]; // Wrong third digit
        rowDigits[2][7] = 4'hF;                  // Arms watermark, key follows
        rowName   = '{"plain copy", "wrong digit", "watermark", "random busy"};
        rowLength = '{8, 8, 16, 8};
        rowCopy   = '{1'b1, 1'b0, 1'b1, 1'b1};
        rowMark   = '{1'b0, 1'b0, 1'b1, 1'b0};
        rowRandom = '{1'b0, 1'b0, 1'b0, 1'b1};
    endtask

    // A drives the data bus only while it is read, B never does
    task automatic checkDirection();
        if (readingB !== 1'b0) reportMismatch("readingB", int'(readingB), 0);
        if (renA === 1'b0 && readingA !== 1'b1) begin
            reportMismatch("readingA", int'(readingA), 1);
        end
        if ((cleA === 1'b1 || aleA === 1'b1) && readingA !== 1'b0) begin
            reportMismatch("readingA", int'(readingA), 0);
        end
    endtask

    // Locked design must leave both buses idle
    task automatic checkIdle();
        for (int c = 0; c < IdleWindow; c++) begin
            nextCycle();
            if (cleA !== 1'b0) reportMismatch("cleA", int'(cleA), 0);
            if (cleB !== 1'b0) reportMismatch("cleB", int'(cleB), 0);
            if (wenA !== 1'b1) reportMismatch("wenA", int'(wenA), 1);
            if (wenB !== 1'b1) reportMismatch("wenB", int'(wenB), 1);
            if (readingA !== 1'b0) reportMismatch("readingA", int'(readingA), 0);
            if (readingB !== 1'b0) reportMismatch("readingB", int'(readingB), 0);
            if (done !== 1'b0) reportMismatch("done", int'(done), 0);
        end
    endtask

    task automatic checkCopy(input int r);
        logic [7:0] want;
        int a;
        int b;
        repeat (10) nextCycle();
        if (done !== 1'b1) reportMismatch("done", int'(done), 1);
        if (modelA.busyStrobes != 0) begin
            reportProblem($sformatf("Row %0d: A was read %0d times while busy",
                r, modelA.busyStrobes));
        end
        if (modelA.ctrlCount != nfcPkg::PageCount * 6) begin
            reportMismatch("modelA.ctrlCount", modelA.ctrlCount, nfcPkg::PageCount * 6);
        end
        if (modelB.ctrlCount != nfcPkg::PageCount * 7) begin
            reportMismatch("modelB.ctrlCount", modelB.ctrlCount, nfcPkg::PageCount * 7);
        end
        for (int p = 0; p < nfcPkg::PageCount; p++) begin
            a = p * 6;
            b = p * 7;
            if (modelA.ctrlLog[a] !== {1'b1, ReadCmd}) begin
                reportMismatch($sformatf("modelA.ctrlLog[%0d]", a),
                    int'(modelA.ctrlLog[a]), int'({1'b1, ReadCmd}));
            end
            if (modelB.ctrlLog[b] !== {1'b1, ProgramCmd}) begin
                reportMismatch($sformatf("modelB.ctrlLog[%0d]", b),
                    int'(modelB.ctrlLog[b]), int'({1'b1, ProgramCmd}));
            end
            if (modelB.ctrlLog[b + 6] !== {1'b1, ConfirmCmd}) begin
                reportMismatch($sformatf("modelB.ctrlLog[%0d]", b + 6),
                    int'(modelB.ctrlLog[b + 6]), int'({1'b1, ConfirmCmd}));
            end
            for (int k = 0; k < 5; k++) begin
                if (modelA.ctrlLog[a + 1 + k] !== addressEntry(p, k)) begin
                    reportMismatch($sformatf("modelA.ctrlLog[%0d]", a + 1 + k),
                        int'(modelA.ctrlLog[a + 1 + k]), int'(addressEntry(p, k)));
                end
                if (modelB.ctrlLog[b + 1 + k] !== addressEntry(p, k)) begin
                    reportMismatch($sformatf("modelB.ctrlLog[%0d]", b + 1 + k),
                        int'(modelB.ctrlLog[b + 1 + k]), int'(addressEntry(p, k)));
                end
            end
            if (modelB.writeCount[p] != nfcPkg::PageBytes) begin
                reportMismatch($sformatf("modelB.writeCount[%0d]", p),
                    modelB.writeCount[p], nfcPkg::PageBytes);
            end
            for (int i = 0; i < nfcPkg::PageBytes; i++) begin
                want = rowMark[r] ? nfcPkg::Watermark[i % 8] : sourceByte(p, i);
                if (modelB.mem[p * nfcPkg::PageBytes + i] !== want) begin
                    reportMismatch($sformatf("modelB page %0d byte %0d", p, i),
                        int'(modelB.mem[p * nfcPkg::PageBytes + i]), int'(want));
                end
            end
        end
    endtask

    task automatic runRow(input int r);
        int cycles;
        rowErrors = 0;
        nextCycle();
        rst        = 1'b1;
        key        = 4'h0;
        randomBusy = rowRandom[r];
        repeat (5) nextCycle();
        rst = 1'b0;
        for (int k = 0; k < rowLength[r]; k++) begin
            key = rowDigits[r][k]; // Sampled on the next rising edge
            nextCycle();
        end
        key = 4'h0;
        if (rowCopy[r]) begin
            cycles = 0;
            while (done !== 1'b1 && cycles < CopyTimeout) begin
                nextCycle();
                cycles++;
                checkDirection();
            end
            if (done !== 1'b1) begin
                reportProblem($sformatf("Row %0d: done did not rise within %0d cycles",
                    r, CopyTimeout));
            end else begin
                checkCopy(r);
            end
        end else begin
            checkIdle();
        end
        if (rowErrors != 0) begin
            failedRows++;
        end
        $display("Row %0d (%s): %0d errors", r, rowName[r], rowErrors);
    endtask

    initial begin
        rst        = 1'b1;
        key        = 4'h0;
        randomBusy = 1'b0;
        buildTable();
        for (int r = 0; r < Rows; r++) begin
            runRow(r);
        end
        $display("Rows run: %0d, rows failed: %0d, errors: %0d", Rows, failedRows, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/nandFlashModel.sv ====
`timescale 1ns/1ns
`default_nettype none

// Cycle based NAND chip, strobes sampled on the rising clock edge
module nandFlashModel #(
    parameter bit Source = 1'b0 // Preload the page pattern
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       randomBusy,
    input  wire logic       cle,
    input  wire logic       ale,
    input  wire logic       ren,
    input  wire logic       wen,
    input  wire logic [7:0] din,
    output logic [7:0]      dout,
    output logic            rb
);

    localparam int MemSize = nfcPkg::PageCount * nfcPkg::PageBytes;
    localparam int LogSize = nfcPkg::PageCount * 8;
    localparam logic [7:0] ReadCmd    = 8'h00;
    localparam logic [7:0] ConfirmCmd = 8'h10;

    logic [7:0]  mem [0:MemSize-1];
    logic [8:0]  ctrlLog [0:LogSize-1]; // {cle, byte} per latched cycle
    int          ctrlCount = 0;
    int          writeCount [0:nfcPkg::PageCount-1];
    int          busyStrobes = 0; // Reads while busy
    int          busyLeft = 0;
    int          addrIndex = 0;
    int          col = 0;
    int          busyTime;
    logic [8:0]  page = '0;
    logic [7:0]  lastCmd = 8'hFF;
    logic [31:0] rngState = 32'h57e0_3d22;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Byte i of page p holds p * 7 + i
    initial begin
        for (int a = 0; a < MemSize; a++) begin
            mem[a] = Source ? 8'((a / nfcPkg::PageBytes) * 7 + a % nfcPkg::PageBytes) : 8'h00;
        end
    end

    assign rb       = (busyLeft == 0);
    assign dout     = mem[{page, col[8:0]}];
    assign busyTime = randomBusy ? 2 + int'(rngState[3:0]) : 4; // At least two cycles

    always @(posedge clk) begin
        if (rst) begin
            ctrlCount   <= 0;
            busyStrobes <= 0;
            busyLeft    <= 0;
            addrIndex   <= 0;
            col         <= 0;
            page        <= '0;
            lastCmd     <= 8'hFF;
            rngState    <= 32'h57e0_3d22;
            for (int p = 0; p < nfcPkg::PageCount; p++) begin
                writeCount[p] <= 0;
            end
        end else begin
            if (busyLeft > 0) begin
                busyLeft <= busyLeft - 1;
            end
            if (!wen && (cle || ale)) begin
                if (ctrlCount < LogSize) begin
                    ctrlLog[ctrlCount] <= {cle, din};
                end
                ctrlCount <= ctrlCount + 1;
                if (cle) begin
                    lastCmd   <= din;
                    addrIndex <= 0;
                    if (din == ConfirmCmd) begin
                        busyLeft <= busyTime; // Program in progress
                        rngState <= xorshift(rngState);
                    end
                end else begin
                    addrIndex <= addrIndex + 1;
                    case (addrIndex)
                        2: page[7:0] <= din;
                        3: page[8]   <= din[0];
                        4: begin
                            col <= 0;
                            if (lastCmd == ReadCmd) begin
                                busyLeft <= busyTime; // Page load into the register
                                rngState <= xorshift(rngState);
                            end
                        end
                        default: begin
                        end
                    endcase
                end
            end else if (!wen) begin
                if (col < nfcPkg::PageBytes) begin
                    mem[{page, col[8:0]}] <= din;
                end
                col              <= col + 1;
                writeCount[page] <= writeCount[page] + 1;
            end
            if (!ren) begin
                col <= col + 1;
                if (busyLeft > 0) begin
                    busyStrobes <= busyStrobes + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

endmodule

`default_nettype wire

// ==== rtl/nandFlashCopier.sv ====
`timescale 1ns/1ns
`default_nettype none

module nandFlashCopier (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [nfcPkg::KeyWidth-1:0]   key,
    output logic                               done,

    // Flash A, source
    input  wire logic [nfcPkg::DataWidth-1:0]  ioInA,
    output logic [nfcPkg::DataWidth-1:0]       ioOutA,
    output logic                               cleA,
    output logic                               aleA,
    output logic                               renA,
    output logic                               wenA,
    output logic                               readingA,
    input  wire logic                          rbA,

    // Flash B, destination
    input  wire logic [nfcPkg::DataWidth-1:0]  ioInB,
    output logic [nfcPkg::DataWidth-1:0]       ioOutB,
    output logic                               cleB,
    output logic                               aleB,
    output logic                               renB,
    output logic                               wenB,
    output logic                               readingB,
    input  wire logic                          rbB
);

    logic unlocked;
    logic watermarkOn;

    nandBusIf busA ();
    nandBusIf busB ();

    keyLock u_keyLock (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .unlocked    (unlocked),
        .watermarkOn (watermarkOn)
    );

    copySequencer u_copySequencer (
        .clk         (clk),
        .rst         (rst),
        .unlocked    (unlocked),
        .watermarkOn (watermarkOn),
        .busA        (busA.ctrl),
        .busB        (busB.ctrl),
        .done        (done)
    );

    // Chip A pins
    assign ioOutA    = busA.ioOut;
    assign cleA      = busA.cle;
    assign aleA      = busA.ale;
    assign renA      = busA.ren;
    assign wenA      = busA.wen;
    assign readingA  = busA.reading;
    assign busA.ioIn = ioInA;
    assign busA.rb   = rbA;

    // Chip B pins
    assign ioOutB    = busB.ioOut;
    assign cleB      = busB.cle;
    assign aleB      = busB.ale;
    assign renB      = busB.ren;
    assign wenB      = busB.wen;
    assign readingB  = busB.reading;
    assign busB.ioIn = ioInB;
    assign busB.rb   = rbB;

endmodule

`default_nettype wire

// ==== rtl/copySequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module copySequencer (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  unlocked,
    input  wire logic  watermarkOn,
    nandBusIf.ctrl     busA,
    nandBusIf.ctrl     busB,
    output logic       done
);

    nfcPkg::seqState state;
    logic active;
    logic [nfcPkg::StepWidth-1:0] step;
    logic [nfcPkg::PageAddrWidth-1:0] page;
    logic [nfcPkg::DataWidth-1:0] addrByte;

    // Mover hand-off
    logic xferStart;
    logic xferDone;
    logic renA;
    logic wenB;
    logic [nfcPkg::DataWidth-1:0] dataB;

    byteMover u_byteMover (
        .clk         (clk),
        .rst         (rst),
        .xferStart   (xferStart),
        .watermarkOn (watermarkOn),
        .rbA         (busA.rb),
        .ioInA       (busA.ioIn),
        .renA        (renA),
        .wenB        (wenB),
        .dataB       (dataB),
        .xferDone    (xferDone)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= nfcPkg::seqCommand;
            active    <= 1'b0;
            step      <= '0;
            page      <= '0;
            done      <= 1'b0;
            xferStart <= 1'b0;
        end else begin
            xferStart <= 1'b0;
            if (!active) begin
                if (unlocked && !done) begin
                    active <= 1'b1; // Command phase begins next cycle
                end
            end else begin
                case (state)
                    nfcPkg::seqCommand: begin
                        step <= step + 1'b1;
                        if (step[0]) begin
                            state <= nfcPkg::seqAddress;
                            step  <= '0;
                        end
                    end
                    nfcPkg::seqAddress: begin
                        step <= step + 1'b1;
                        if (step == nfcPkg::AddrLastStep) begin
                            state     <= nfcPkg::seqTransfer;
                            step      <= '0;
                            xferStart <= 1'b1;
                        end
                    end
                    nfcPkg::seqTransfer: begin
                        if (xferDone) begin
                            state <= nfcPkg::seqConfirm;
                        end
                    end
                    nfcPkg::seqConfirm: begin
                        step <= step + 1'b1;
                        if (step[0]) begin
                            state <= nfcPkg::seqWaitBusy;
                            step  <= '0;
                        end
                    end
                    nfcPkg::seqWaitBusy: begin
                        if (!busB.rb) begin
                            state <= nfcPkg::seqWaitReady;
                        end
                    end
                    nfcPkg::seqWaitReady: begin
                        if (busB.rb) begin
                            state <= nfcPkg::seqCommand;
                            page  <= page + 1'b1;
                            if (page == nfcPkg::LastPage) begin
                                done   <= 1'b1;
                                active <= 1'b0; // Idle for good
                            end
                        end
                    end
                    default: state <= nfcPkg::seqCommand;
                endcase
            end
        end
    end

    // Column 0, column 0, page low byte, page high bit, idle byte
    always_comb begin
        case (step[3:1])
            3'd2:    addrByte = page[nfcPkg::DataWidth-1:0];
            3'd3:    addrByte = {{(nfcPkg::DataWidth-1){1'b0}}, page[nfcPkg::PageAddrWidth-1]};
            default: addrByte = '0;
        endcase
    end

    always_comb begin
        busA.cle     = 1'b0;
        busA.ale     = 1'b0;
        busA.ren     = 1'b1;
        busA.wen     = 1'b1;
        busA.reading = 1'b0;
        busA.ioOut   = '0;
        busB.cle     = 1'b0;
        busB.ale     = 1'b0;
        busB.ren     = 1'b1;
        busB.wen     = 1'b1;
        busB.reading = 1'b0;
        busB.ioOut   = '0;
        if (active) begin
            case (state)
                nfcPkg::seqCommand: begin
                    busA.cle   = 1'b1;
                    busB.cle   = 1'b1;
                    busA.wen   = step[0]; // Low then high
                    busB.wen   = step[0];
                    busA.ioOut = nfcPkg::CmdRead;
                    busB.ioOut = nfcPkg::CmdProgram;
                end
                nfcPkg::seqAddress: begin
                    busA.ale   = 1'b1;
                    busB.ale   = 1'b1;
                    busA.wen   = step[0];
                    busB.wen   = step[0];
                    busA.ioOut = addrByte;
                    busB.ioOut = addrByte;
                end
                nfcPkg::seqTransfer: begin
                    busA.reading = 1'b1;
                    busA.ren     = renA;
                    busB.wen     = wenB;
                    busB.ioOut   = dataB;
                end
                nfcPkg::seqConfirm: begin
                    busB.cle   = 1'b1;
                    busB.wen   = step[0];
                    busB.ioOut = nfcPkg::CmdProgramConfirm;
                end
                default: begin
                    // Waiting on B ready/busy, buses stay idle
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/byteMover.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteMover (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          xferStart,
    input  wire logic                          watermarkOn,
    input  wire logic                          rbA,
    input  wire logic [nfcPkg::DataWidth-1:0]  ioInA,
    output logic                               renA,
    output logic                               wenB,
    output logic [nfcPkg::DataWidth-1:0]       dataB,
    output logic                               xferDone
);

    logic moving;     // Page transfer in progress
    logic writePhase; // Second half of a byte, strobing B
    logic readNow;
    logic [nfcPkg::ByteCountWidth-1:0] count;
    logic [nfcPkg::DataWidth-1:0] captured;

    // A is only strobed when it reports ready
    assign readNow = moving && !writePhase && rbA;

    always_ff @(posedge clk) begin
        if (rst) begin
            moving     <= 1'b0;
            writePhase <= 1'b0;
            count      <= '0;
            xferDone   <= 1'b0;
        end else begin
            xferDone <= 1'b0;
            if (xferStart) begin
                moving     <= 1'b1;
                writePhase <= 1'b0;
                count      <= '0;
            end else if (moving) begin
                if (writePhase) begin
                    writePhase <= 1'b0;
                    count      <= count + 1'b1;
                    if (count == nfcPkg::LastByte) begin
                        moving   <= 1'b0;
                        xferDone <= 1'b1; // One cycle after the last write
                    end
                end else if (rbA) begin
                    writePhase <= 1'b1;
                end
            end
        end
    end

    // Byte from A, sampled at the end of the ren low cycle
    always_ff @(posedge clk) begin
        if (readNow) begin
            captured <= ioInA;
        end
    end

    assign renA = !readNow;
    assign wenB = !(moving && writePhase);

    // Pattern repeats every eight bytes
    assign dataB = watermarkOn ? nfcPkg::Watermark[count[2:0]] : captured;

endmodule

`default_nettype wire

// ==== rtl/keyLock.sv ====
`timescale 1ns/1ns
`default_nettype none

module keyLock (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [nfcPkg::KeyWidth-1:0]  key,
    output logic                              unlocked,
    output logic                              watermarkOn
);

    nfcPkg::lockState state;
    logic [nfcPkg::KeyWidth-1:0] expected;

    // Digit states are numbered 0..7, so the low bits index the key
    assign expected = nfcPkg::UnlockKey[state[2:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= nfcPkg::checkDigit0;
            watermarkOn <= 1'b0;
        end else begin
            case (state)
                nfcPkg::keyUnlocked: begin
                    state <= nfcPkg::keyUnlocked; // Stays open until reset
                end
                nfcPkg::keyDead: begin
                    state <= nfcPkg::keyDead;
                end
                nfcPkg::checkDigit7: begin
                    if (key == expected) begin
                        state <= nfcPkg::keyUnlocked;
                    end else if (key == nfcPkg::WatermarkKey) begin
                        // Arm watermark and ask for the key again
                        watermarkOn <= 1'b1;
                        state       <= nfcPkg::checkDigit0;
                    end else begin
                        state <= nfcPkg::keyDead;
                    end
                end
                default: begin
                    if (key == expected) begin
                        state <= nfcPkg::lockState'(state + 4'd1);
                    end else begin
                        state <= nfcPkg::keyDead; // Any wrong digit is fatal
                    end
                end
            endcase
        end
    end

    assign unlocked = (state == nfcPkg::keyUnlocked);

endmodule

`default_nettype wire

// ==== rtl/nandBusIf.sv ====
`timescale 1ns/1ns
`default_nettype none

// One flash chip's pins, split data in/out
interface nandBusIf;

    logic cle;
    logic ale;
    logic ren;    // Active low
    logic wen;    // Active low
    logic reading; // High while the chip drives the data bus
    logic [nfcPkg::DataWidth-1:0] ioOut;
    logic [nfcPkg::DataWidth-1:0] ioIn;
    logic rb;     // Low while busy

    modport ctrl (
        output cle,
        output ale,
        output ren,
        output wen,
        output ioOut,
        output reading,
        input  ioIn,
        input  rb
    );

    modport pins (
        input  cle,
        input  ale,
        input  ren,
        input  wen,
        input  ioOut,
        input  reading,
        output ioIn,
        output rb
    );

endinterface

`default_nettype wire

// ==== rtl/nfcPkg.sv ====
`default_nettype none

package nfcPkg;

    // Flash geometry
    localparam int PageCount      = 512;
    localparam int PageBytes      = 512;
    localparam int PageAddrWidth  = 9;
    localparam int ByteCountWidth = 9;
    localparam int DataWidth      = 8;
    localparam int AddrBytes      = 5; // Two column, two row, one idle

    localparam logic [PageAddrWidth-1:0]  LastPage = PageAddrWidth'(PageCount - 1);
    localparam logic [ByteCountWidth-1:0] LastByte = ByteCountWidth'(PageBytes - 1);

    // Sequencer step counter, two cycles per command or address byte
    localparam int StepWidth = 4;
    localparam logic [StepWidth-1:0] AddrLastStep = StepWidth'(2 * AddrBytes - 1);

    // NAND command bytes
    localparam logic [DataWidth-1:0] CmdRead           = 8'h00;
    localparam logic [DataWidth-1:0] CmdProgram        = 8'h80;
    localparam logic [DataWidth-1:0] CmdProgramConfirm = 8'h10;

    // Unlock key, one digit per clock
    localparam int KeyWidth  = 4;
    localparam int KeyLength = 8;
    localparam logic [KeyWidth-1:0] UnlockKey [0:KeyLength-1] = '{
        4'h5, 4'h0, 4'h5, 4'h9, 4'h5, 4'h0, 4'h4, 4'h4
    };
    localparam logic [KeyWidth-1:0] WatermarkKey = 4'hF; // Replaces the last digit

    // Watermark pattern written in place of A data
    localparam int WatermarkLength = 8;
    localparam logic [DataWidth-1:0] Watermark [0:WatermarkLength-1] = '{
        8'h50, 8'h59, 8'h20, 8'h70, 8'h61, 8'h72, 8'h74, 8'h79
    };

    typedef enum logic [3:0] {
        checkDigit0, checkDigit1, checkDigit2, checkDigit3,
        checkDigit4, checkDigit5, checkDigit6, checkDigit7,
        keyUnlocked,
        keyDead
    } lockState;

    typedef enum logic [2:0] {
        seqCommand,
        seqAddress,
        seqTransfer,
        seqConfirm,
        seqWaitBusy,
        seqWaitReady
    } seqState;

endpackage

`default_nettype wire
